//--- logic/rvIsaPkg.sv
package rvIsaPkg;

    typedef logic [31:0] instr_t;   // Raw instruction word
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [4:0]  regAddr_t; // Register index x0..x31

    // Only the two integer ALU opcode groups are decoded
    localparam opcode_t OP_REG = 7'b0110011; // R-type ALU
    localparam opcode_t OP_IMM = 7'b0010011; // I-type ALU

    localparam funct3_t F3_ADD  = 3'b000; // ADD, SUB, ADDI
    localparam funct3_t F3_SLL  = 3'b001; // SLL, SLLI
    localparam funct3_t F3_SLT  = 3'b010; // SLT, SLTI
    localparam funct3_t F3_SLTU = 3'b011; // SLTU, SLTIU
    localparam funct3_t F3_XOR  = 3'b100; // XOR, XORI
    localparam funct3_t F3_SR   = 3'b101; // SRL, SRA and immediates
    localparam funct3_t F3_OR   = 3'b110; // OR, ORI
    localparam funct3_t F3_AND  = 3'b111; // AND, ANDI

endpackage

//--- logic/coreCtrlPkg.sv
package coreCtrlPkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t; // Datapath word
    typedef logic [3:0]      aluOp_t;

    // ALU operation codes
    // Code 8 is left free, SRAI runs on the SRA code
    localparam aluOp_t ALU_ADD  = 4'd0;
    localparam aluOp_t ALU_SUB  = 4'd1;
    localparam aluOp_t ALU_AND  = 4'd2;
    localparam aluOp_t ALU_OR   = 4'd3;
    localparam aluOp_t ALU_XOR  = 4'd4;
    localparam aluOp_t ALU_SLL  = 4'd5;
    localparam aluOp_t ALU_SRL  = 4'd6;
    localparam aluOp_t ALU_SRA  = 4'd7;
    localparam aluOp_t ALU_SLT  = 4'd9;
    localparam aluOp_t ALU_SLTU = 4'd10;

endpackage

//--- logic/dualDecode.sv
module dualDecode
    import rvIsaPkg::*, coreCtrlPkg::*;
(
    input  instr_t   instrA,
    input  instr_t   instrB,
    output regAddr_t rs1A,
    output regAddr_t rs2A,
    output regAddr_t rdA,
    output regAddr_t rs1B,
    output regAddr_t rs2B,
    output regAddr_t rdB,
    output aluOp_t   aluOpA,
    output aluOp_t   aluOpB,
    output logic     useImmA,
    output logic     useImmB,
    output word_t    immA,
    output word_t    immB,
    output logic     regWriteA,
    output logic     regWriteB
);

    // Same decode for either slot
    function automatic void decodeSlot(
        input  instr_t instr,
        output aluOp_t aluOp,
        output logic   useImm,
        output word_t  imm,
        output logic   regWrite
    );
        opcode_t op;
        funct3_t f3;
        logic    alt;
        op       = instr[6:0];
        f3       = instr[14:12];
        alt      = instr[30];                   // funct7 bit 5
        aluOp    = ALU_ADD;
        useImm   = 1'b0;
        imm      = '0;
        regWrite = 1'b0;
        case (op)
            OP_REG: begin
                regWrite = 1'b1;
                case (f3)
                    F3_ADD:  aluOp = alt ? ALU_SUB : ALU_ADD;
                    F3_SLL:  aluOp = ALU_SLL;
                    F3_SLT:  aluOp = ALU_SLT;
                    F3_SLTU: aluOp = ALU_SLTU;
                    F3_XOR:  aluOp = ALU_XOR;
                    F3_SR:   aluOp = alt ? ALU_SRA : ALU_SRL;
                    F3_OR:   aluOp = ALU_OR;
                    F3_AND:  aluOp = ALU_AND;
                endcase
            end
            OP_IMM: begin
                regWrite = 1'b1;
                useImm   = 1'b1;
                imm      = {{(XLEN-12){instr[31]}}, instr[31:20]}; // Sign-extended I-imm
                case (f3)
                    F3_ADD:  aluOp = ALU_ADD;
                    F3_SLL: begin
                        aluOp    = ALU_SLL;
                        imm      = {{(XLEN-5){1'b0}}, instr[24:20]};
                        regWrite = !alt;        // Bit 30 set is not a legal SLLI
                    end
                    F3_SLT:  aluOp = ALU_SLT;
                    F3_SLTU: aluOp = ALU_SLTU;
                    F3_XOR:  aluOp = ALU_XOR;
                    F3_SR: begin
                        aluOp = alt ? ALU_SRA : ALU_SRL;
                        imm   = {{(XLEN-5){1'b0}}, instr[24:20]}; // Shamt only
                    end
                    F3_OR:   aluOp = ALU_OR;
                    F3_AND:  aluOp = ALU_AND;
                endcase
            end
            default: regWrite = 1'b0;           // Unsupported opcode
        endcase
        if (instr[11:7] == 5'd0) begin
            regWrite = 1'b0;                    // x0 is never written
        end
    endfunction

    assign rs1A = instrA[19:15];
    assign rs2A = instrA[24:20];
    assign rdA  = instrA[11:7];
    assign rs1B = instrB[19:15];
    assign rs2B = instrB[24:20];
    assign rdB  = instrB[11:7];

    always_comb begin
        decodeSlot(instrA, aluOpA, useImmA, immA, regWriteA);
        decodeSlot(instrB, aluOpB, useImmB, immB, regWriteB);
    end

endmodule

//--- logic/regFile.sv
module regFile
    import rvIsaPkg::*, coreCtrlPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  regAddr_t raddrA1,
    input  regAddr_t raddrA2,
    input  regAddr_t raddrB1,
    input  regAddr_t raddrB2,
    input  regAddr_t waddrA,
    input  regAddr_t waddrB,
    input  logic     weA,
    input  logic     weB,
    input  word_t    wdataA,
    input  word_t    wdataB,
    output word_t    rdataA1,
    output word_t    rdataA2,
    output word_t    rdataB1,
    output word_t    rdataB2
);

    word_t regs [1:31]; // x0 has no storage

    function automatic word_t readReg(input regAddr_t addr);
        if (addr == 5'd0) begin
            readReg = '0;
        end else begin
            readReg = regs[addr];
        end
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (weA && waddrA != 5'd0) begin
                regs[waddrA] <= wdataA;
            end
            if (weB && waddrB != 5'd0) begin
                regs[waddrB] <= wdataB; // Issued last so B wins a conflict
            end
        end
    end

    always_comb begin
        rdataA1 = readReg(raddrA1);
        rdataA2 = readReg(raddrA2);
        rdataB1 = readReg(raddrB1);
        rdataB2 = readReg(raddrB2);
    end

endmodule

//--- logic/operandBypass.sv
module operandBypass
    import rvIsaPkg::*, coreCtrlPkg::*;
(
    input  regAddr_t raddrA1,
    input  regAddr_t raddrA2,
    input  regAddr_t raddrB1,
    input  regAddr_t raddrB2,
    input  word_t    rdataA1,
    input  word_t    rdataA2,
    input  word_t    rdataB1,
    input  word_t    rdataB2,
    input  logic     exValid,
    input  logic     exWeA,
    input  logic     exWeB,
    input  regAddr_t exRdA,
    input  regAddr_t exRdB,
    input  word_t    exResA,
    input  word_t    exResB,
    output word_t    opA1,
    output word_t    opA2,
    output word_t    opB1,
    output word_t    opB2
);

    logic hitA [4];
    logic hitB [4];
    regAddr_t addr [4];
    word_t    rdata [4];
    word_t    operand [4];

    assign addr[0]  = raddrA1;
    assign addr[1]  = raddrA2;
    assign addr[2]  = raddrB1;
    assign addr[3]  = raddrB2;
    assign rdata[0] = rdataA1;
    assign rdata[1] = rdataA2;
    assign rdata[2] = rdataB1;
    assign rdata[3] = rdataB2;

    // The execute bundle is the only one not yet in the register file
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            hitA[i] = exValid && exWeA && (exRdA == addr[i]) && (addr[i] != 5'd0);
            hitB[i] = exValid && exWeB && (exRdB == addr[i]) && (addr[i] != 5'd0);
            if (hitB[i]) begin
                operand[i] = exResB;         // Slot B is younger
            end else if (hitA[i]) begin
                operand[i] = exResA;
            end else begin
                operand[i] = rdata[i];
            end
        end
    end

    assign opA1 = operand[0];
    assign opA2 = operand[1];
    assign opB1 = operand[2];
    assign opB2 = operand[3];

endmodule

//--- logic/executeStage.sv
module executeStage
    import rvIsaPkg::*, coreCtrlPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     issueValid,
    input  word_t    opA1,
    input  word_t    opA2,
    input  word_t    opB1,
    input  word_t    opB2,
    input  word_t    immA,
    input  word_t    immB,
    input  aluOp_t   aluOpA,
    input  aluOp_t   aluOpB,
    input  logic     useImmA,
    input  logic     useImmB,
    input  logic     regWriteA,
    input  logic     regWriteB,
    input  regAddr_t rdA,
    input  regAddr_t rdB,
    output logic     exValid,
    output logic     exWeA,
    output logic     exWeB,
    output regAddr_t exRdA,
    output regAddr_t exRdB,
    output word_t    exResA,
    output word_t    exResB
);

    aluOp_t aluOpAQ;
    aluOp_t aluOpBQ;
    word_t  srcA1Q;
    word_t  srcA2Q;
    word_t  srcB1Q;
    word_t  srcB2Q;
    logic   regWriteAQ;
    logic   regWriteBQ;

    function automatic word_t aluCalc(input aluOp_t op, input word_t a, input word_t b);
        logic [4:0] shamt;
        shamt = b[4:0];                          // Shift amount from low bits only
        case (op)
            ALU_ADD:  aluCalc = a + b;
            ALU_SUB:  aluCalc = a - b;
            ALU_AND:  aluCalc = a & b;
            ALU_OR:   aluCalc = a | b;
            ALU_XOR:  aluCalc = a ^ b;
            ALU_SLL:  aluCalc = a << shamt;
            ALU_SRL:  aluCalc = a >> shamt;
            ALU_SRA:  aluCalc = word_t'($signed(a) >>> shamt);
            ALU_SLT:  aluCalc = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: aluCalc = {{(XLEN-1){1'b0}}, a < b};
            default:  aluCalc = '0;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exValid    <= 1'b0;
            regWriteAQ <= 1'b0;
            regWriteBQ <= 1'b0;
            aluOpAQ    <= '0;
            aluOpBQ    <= '0;
            srcA1Q     <= '0;
            srcA2Q     <= '0;
            srcB1Q     <= '0;
            srcB2Q     <= '0;
            exRdA      <= '0;
            exRdB      <= '0;
        end else begin
            exValid    <= issueValid;
            regWriteAQ <= regWriteA;
            regWriteBQ <= regWriteB;
            aluOpAQ    <= aluOpA;
            aluOpBQ    <= aluOpB;
            srcA1Q     <= opA1;
            srcA2Q     <= useImmA ? immA : opA2; // Immediate replaces rs2
            srcB1Q     <= opB1;
            srcB2Q     <= useImmB ? immB : opB2;
            exRdA      <= rdA;
            exRdB      <= rdB;
        end
    end

    assign exWeA  = exValid && regWriteAQ;
    assign exWeB  = exValid && regWriteBQ;
    assign exResA = aluCalc(aluOpAQ, srcA1Q, srcA2Q);
    assign exResB = aluCalc(aluOpBQ, srcB1Q, srcB2Q);

endmodule

//--- logic/writebackStage.sv
module writebackStage
    import rvIsaPkg::*, coreCtrlPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     exValid,
    input  logic     exWeA,
    input  logic     exWeB,
    input  regAddr_t exRdA,
    input  regAddr_t exRdB,
    input  word_t    exResA,
    input  word_t    exResB,
    output logic     wbEnA,
    output regAddr_t wbRdA,
    output word_t    wbDataA,
    output logic     wbEnB,
    output regAddr_t wbRdB,
    output word_t    wbDataB
);

    // Visible record of what the register file takes at this same edge
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbEnA   <= 1'b0;
            wbEnB   <= 1'b0;
            wbRdA   <= '0;
            wbRdB   <= '0;
            wbDataA <= '0;
            wbDataB <= '0;
        end else begin
            wbEnA   <= exValid && exWeA;
            wbEnB   <= exValid && exWeB;
            wbRdA   <= exRdA;
            wbRdB   <= exRdB;
            wbDataA <= exResA;
            wbDataB <= exResB;
        end
    end

endmodule

//--- logic/dualIssueCore.sv
module dualIssueCore
    import rvIsaPkg::*, coreCtrlPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     issueValid,
    input  instr_t   instrA,
    input  instr_t   instrB,
    output logic     wbEnA,
    output regAddr_t wbRdA,
    output word_t    wbDataA,
    output logic     wbEnB,
    output regAddr_t wbRdB,
    output word_t    wbDataB
);

    regAddr_t rs1A, rs2A, rdA, rs1B, rs2B, rdB;
    aluOp_t   aluOpA, aluOpB;
    logic     useImmA, useImmB, regWriteA, regWriteB;
    word_t    immA, immB;
    word_t    rdataA1, rdataA2, rdataB1, rdataB2;
    word_t    opA1, opA2, opB1, opB2;
    logic     exValid, exWeA, exWeB;
    regAddr_t exRdA, exRdB;
    word_t    exResA, exResB;

    dualDecode decode_i (
        .instrA, .instrB, .rs1A, .rs2A, .rdA, .rs1B, .rs2B, .rdB,
        .aluOpA, .aluOpB, .useImmA, .useImmB, .immA, .immB, .regWriteA, .regWriteB
    );

    // Write ports fed from execute, same edge as the write-back record
    regFile regs_i (
        .clk, .rstN,
        .raddrA1(rs1A), .raddrA2(rs2A), .raddrB1(rs1B), .raddrB2(rs2B),
        .waddrA(exRdA), .waddrB(exRdB), .weA(exWeA), .weB(exWeB),
        .wdataA(exResA), .wdataB(exResB),
        .rdataA1, .rdataA2, .rdataB1, .rdataB2
    );

    operandBypass bypass_i (
        .raddrA1(rs1A), .raddrA2(rs2A), .raddrB1(rs1B), .raddrB2(rs2B),
        .rdataA1, .rdataA2, .rdataB1, .rdataB2,
        .exValid, .exWeA, .exWeB, .exRdA, .exRdB, .exResA, .exResB,
        .opA1, .opA2, .opB1, .opB2
    );

    executeStage execute_i (
        .clk, .rstN, .issueValid, .opA1, .opA2, .opB1, .opB2, .immA, .immB,
        .aluOpA, .aluOpB, .useImmA, .useImmB, .regWriteA, .regWriteB, .rdA, .rdB,
        .exValid, .exWeA, .exWeB, .exRdA, .exRdB, .exResA, .exResB
    );

    writebackStage writeback_i (
        .clk, .rstN, .exValid, .exWeA, .exWeB, .exRdA, .exRdB, .exResA, .exResB,
        .wbEnA, .wbRdA, .wbDataA, .wbEnB, .wbRdB, .wbDataB
    );

endmodule

//--- testbench/clockGen.sv
module clockGen (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // Period of 20
    end

    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

//--- testbench/coreChecker.sv
module coreChecker
    import rvIsaPkg::*, coreCtrlPkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  logic     issueValid,
    input  instr_t   instrA,
    input  instr_t   instrB,
    input  logic     wbEnA,
    input  regAddr_t wbRdA,
    input  word_t    wbDataA,
    input  logic     wbEnB,
    input  regAddr_t wbRdB,
    input  word_t    wbDataB,
    output int       errorCount,
    output int       checkCount
);

    typedef struct packed {
        logic     enA;
        regAddr_t rdA;
        word_t    dataA;
        logic     enB;
        regAddr_t rdB;
        word_t    dataB;
    } wbRec_t;

    word_t  model [32];    // Architectural state after every bundle issued so far
    wbRec_t expected [$];  // One entry per active cycle, idle ones included
    int     errors = 0;
    int     checks = 0;

    assign errorCount = errors;
    assign checkCount = checks;

    initial begin
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
    end

    // RV32I result of one ALU instruction against the model state
    function automatic void refSlot(input instr_t instr, output logic en, output word_t val);
        word_t      a;
        word_t      b;
        logic [4:0] sh;
        logic       isImm;
        isImm = (instr[6:0] == OP_IMM);
        a     = model[instr[19:15]];
        b     = isImm ? {{20{instr[31]}}, instr[31:20]} : model[instr[24:20]];
        sh    = b[4:0];
        en    = (isImm || instr[6:0] == OP_REG) && (instr[11:7] != 5'd0);
        case (instr[14:12])
            F3_ADD:  val = (!isImm && instr[30]) ? a - b : a + b;
            F3_SLL: begin
                val = a << sh;
                if (isImm && instr[30]) begin
                    en = 1'b0; // Not a legal SLLI
                end
            end
            F3_SLT:  val = {31'd0, $signed(a) < $signed(b)};
            F3_SLTU: val = {31'd0, a < b};
            F3_XOR:  val = a ^ b;
            F3_SR: begin
                if (instr[30]) begin
                    val = word_t'($signed(a) >>> sh);
                end else begin
                    val = a >> sh;
                end
            end
            F3_OR:   val = a | b;
            default: val = a & b;
        endcase
    endfunction

    task automatic compareSlot(input string slot, input logic expEn, input regAddr_t expRd,
                               input word_t expData, input logic en, input regAddr_t rd,
                               input word_t data);
        checks++;
        if (en !== expEn) begin
            errors++;
            $display("[ERROR] %0t: slot %s wbEn is %b, expected %b", $time, slot, en, expEn);
        end else if (expEn && (rd !== expRd || data !== expData)) begin
            errors++;
            $display("[ERROR] %0t: slot %s wrote x%0d = %h, expected x%0d = %h",
                     $time, slot, rd, data, expRd, expData);
        end
    endtask

    always @(posedge clk) begin : predict
        wbRec_t rec;
        logic   enA;
        logic   enB;
        word_t  valA;
        word_t  valB;
        rec = '0;
        if (rstN) begin
            if (issueValid) begin
                refSlot(instrA, enA, valA); // Both slots see pre-bundle state
                refSlot(instrB, enB, valB);
                rec = '{enA, instrA[11:7], valA, enB, instrB[11:7], valB};
                if (enA) begin
                    model[instrA[11:7]] = valA;
                end
                if (enB) begin
                    model[instrB[11:7]] = valB; // B last so it wins
                end
            end
            expected.push_back(rec);
        end
    end

    // Outputs settle after the rising edge
    always @(negedge clk) begin : compare
        wbRec_t rec;
        if (!rstN || expected.size() < 2) begin
            checks++;
            if (wbEnA !== 1'b0 || wbEnB !== 1'b0) begin
                errors++;
                $display("[ERROR] %0t: write-back seen with no bundle issued", $time);
            end
        end else begin
            rec = expected.pop_front();
            compareSlot("A", rec.enA, rec.rdA, rec.dataA, wbEnA, wbRdA, wbDataA);
            compareSlot("B", rec.enB, rec.rdB, rec.dataB, wbEnB, wbRdB, wbDataB);
        end
    end

endmodule

//--- testbench/dualIssue_asserts.sv
module dualIssueAsserts
    import rvIsaPkg::*;
(
    input logic     clk,
    input logic     rstN,
    input logic     issueValid,
    input instr_t   instrA,
    input instr_t   instrB,
    input logic     wbEnA,
    input regAddr_t wbRdA,
    input logic     wbEnB,
    input regAddr_t wbRdB
);

    resetQuiet: assert property (@(posedge clk) !rstN |=> (!wbEnA && !wbEnB))
        else $error("write-back enable high right after a reset cycle");

    // Sampled at one edge, on the write-back ports after the next one
    recordFollowsIssue: assert property (@(posedge clk) disable iff (!rstN)
        issueValid |-> ##2 ((wbRdA == $past(instrA[11:7], 2))
                            && (wbRdB == $past(instrB[11:7], 2))))
        else $error("write-back record did not follow the issued bundle");

    noWriteWithoutIssue: assert property (@(posedge clk) disable iff (!rstN)
        !issueValid |=> ##1 (!wbEnA && !wbEnB))
        else $error("write-back seen without a prior issue");

endmodule

bind dualIssueCore dualIssueAsserts asserts_i (
    .clk,
    .rstN,
    .issueValid,
    .instrA,
    .instrB,
    .wbEnA,
    .wbRdA,
    .wbEnB,
    .wbRdB
);

//--- testbench/coreTb.sv
module coreTb
    import rvIsaPkg::*, coreCtrlPkg::*;
();

    localparam int numDirected = 30;
    localparam int numRandom   = 200;
    localparam int maxCycles   = numDirected + numRandom + 20;

    logic     clk;
    logic     rstN;
    logic     issueValid;
    instr_t   instrA;
    instr_t   instrB;
    logic     wbEnA;
    regAddr_t wbRdA;
    word_t    wbDataA;
    logic     wbEnB;
    regAddr_t wbRdB;
    word_t    wbDataB;
    int       errorCount;
    int       checkCount;
    int       cycleCount = 0;

    clockGen clock_i (.clk, .rstN);

    dualIssueCore dut_i (
        .clk, .rstN, .issueValid, .instrA, .instrB,
        .wbEnA, .wbRdA, .wbDataA, .wbEnB, .wbRdB, .wbDataB
    );

    coreChecker checker_i (
        .clk, .rstN, .issueValid, .instrA, .instrB,
        .wbEnA, .wbRdA, .wbDataA, .wbEnB, .wbRdB, .wbDataB,
        .errorCount, .checkCount
    );

    function automatic instr_t rType(input funct3_t f3, input logic alt, input regAddr_t rd,
                                     input regAddr_t rs1, input regAddr_t rs2);
        rType = {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic instr_t iType(input funct3_t f3, input logic [11:0] imm,
                                     input regAddr_t rd, input regAddr_t rs1);
        iType = {imm, rs1, f3, rd, OP_IMM};
    endfunction

    // Registers kept to x0..x7 so that bundles often depend on each other
    function automatic instr_t randomInstr();
        instr_t w;
        w = $urandom;
        w[11:7]  = {2'b00, w[9:7]};
        w[19:15] = {2'b00, w[17:15]};
        w[24:20] = {2'b00, w[22:20]};
        case ($urandom_range(7))
            0:       w[6:0] = w[6:0]; // Mostly unsupported opcodes
            1, 2, 3: w[6:0] = OP_REG;
            default: w[6:0] = OP_IMM;
        endcase
        randomInstr = w;
    endfunction

    task automatic issueBundle(input instr_t a, input instr_t b);
        @(posedge clk);
        issueValid <= 1'b1;
        instrA     <= a;
        instrB     <= b;
    endtask

    task automatic idleCycle();
        @(posedge clk);
        issueValid <= 1'b0;
        instrA     <= '0;
        instrB     <= '0;
    endtask

    initial begin
        issueValid = 1'b0;
        instrA     = '0;
        instrB     = '0;
        void'($urandom(26));
        wait (rstN === 1'b1);
        issueBundle(iType(F3_ADD, 12'hffb, 5'd1, 5'd0), iType(F3_ADD, 12'h7ff, 5'd2, 5'd0));
        issueBundle(iType(F3_ADD, 12'h800, 5'd3, 5'd0), iType(F3_ADD, 12'h003, 5'd4, 5'd0));
        for (int f = 0; f < 8; f++) begin
            issueBundle(rType(funct3_t'(f), 1'b0, 5'd5, 5'd1, 5'd2),
                        rType(funct3_t'(f), (f == 0) || (f == 5), 5'd6, 5'd3, 5'd1));
        end
        issueBundle(rType(F3_ADD, 1'b1, 5'd7, 5'd1, 5'd2), rType(F3_SR, 1'b0, 5'd8, 5'd3, 5'd4));
        for (int f = 0; f < 8; f++) begin
            issueBundle(iType(funct3_t'(f), (f == 1) ? 12'h005 : (f == 5) ? 12'h404 : 12'hff9,
                              5'd9, 5'd1),
                        iType(funct3_t'(f), (f == 1) ? 12'h01f : (f == 5) ? 12'h003 : 12'h123,
                              5'd10, 5'd3));
        end
        issueBundle(iType(F3_SLL, 12'h402, 5'd11, 5'd1), iType(F3_SLTU, 12'hfff, 5'd11, 5'd1));
        // Forwarding across bundles, none inside one
        issueBundle(iType(F3_ADD, 12'h064, 5'd12, 5'd1), iType(F3_ADD, 12'h001, 5'd13, 5'd12));
        issueBundle(rType(F3_ADD, 1'b0, 5'd14, 5'd12, 5'd13),
                    rType(F3_ADD, 1'b1, 5'd15, 5'd13, 5'd12));
        // Same destination in both slots
        issueBundle(iType(F3_ADD, 12'h001, 5'd16, 5'd0), iType(F3_ADD, 12'h002, 5'd16, 5'd0));
        issueBundle(rType(F3_ADD, 1'b0, 5'd17, 5'd16, 5'd0), iType(F3_ADD, 12'h000, 5'd18, 5'd16));
        idleCycle();
        issueBundle(rType(F3_ADD, 1'b0, 5'd19, 5'd16, 5'd16), rType(F3_OR, 1'b0, 5'd20, 5'd16, 5'd0));
        issueBundle(iType(F3_ADD, 12'h005, 5'd0, 5'd1), 32'h0000_2083); // x0 and a load
        repeat (3) idleCycle();
        for (int n = 0; n < numRandom; n++) begin
            if ($urandom_range(3) == 0) begin
                idleCycle();
            end else begin
                issueBundle(randomInstr(), randomInstr());
            end
        end
        repeat (4) idleCycle(); // Drain the pipeline
        @(negedge clk);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        while (cycleCount < maxCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d cycles", maxCycles);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- files.f
logic/rvIsaPkg.sv
logic/coreCtrlPkg.sv
logic/dualDecode.sv
logic/regFile.sv
logic/operandBypass.sv
logic/executeStage.sv
logic/writebackStage.sv
logic/dualIssueCore.sv
testbench/clockGen.sv
testbench/coreChecker.sv
testbench/dualIssue_asserts.sv
testbench/coreTb.sv

//--- Makefile
SOURCES := $(shell cat files.f)

obj_dir/VcoreTb: files.f $(SOURCES)
	verilator --binary --timing --assert --top-module coreTb -f files.f

run: obj_dir/VcoreTb
	./obj_dir/VcoreTb > sim.log; cat sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
